//--- source/pingPongPkg.sv
`default_nettype none

package pingPongPkg;

   // ********************
   // line and tag types
   // ********************
   typedef logic [511:0] cacheLineT;   // one cache line
   typedef logic [15:0]  tagT;         // bit 15 set on reads

   // notification method, from testCfg[7:6]
   typedef enum logic [1:0]
   {
      notifyPoll = 2'd0,   // poll the flag line
      notifyCsr  = 2'd1    // host CSR write strobe
   } notifyModeT;

   // ********************
   // state encodings
   // ********************
   typedef enum logic [2:0]
   {
      wrWaitS  = 3'd0,   // idle until go
      wrWriteS = 3'd1,   // stream payload lines
      wrFenceS = 3'd2,   // write fence
      wrFlagS  = 3'd3,   // flag line to host
      wrDoneS  = 3'd4
   } wrStateT;

   typedef enum logic [1:0]
   {
      rdWaitS  = 2'd0,   // poll reads pass through here
      rdReadS  = 2'd1,
      rdDrainS = 2'd2,   // all issued, wait on responses
      rdDoneS  = 2'd3
   } rdStateT;

   typedef enum logic [1:0]
   {
      pollWaitS = 2'd0,
      pollReadS = 2'd1,
      pollRespS = 2'd2,
      pollDoneS = 2'd3
   } pollStateT;

   // ********************
   // line constants
   // ********************
   localparam cacheLineT   PAYLOAD_FILL = {16{32'h0000_0001}};
   localparam cacheLineT   FLAG_LINE    = {{448{1'b0}}, {64{1'b1}}};
   localparam logic [31:0] FLAG_WORD    = 32'hffff_ffff;   // expected in bits 63:32

endpackage

`default_nettype wire

//--- source/rdReqIf.sv
`timescale 1ns/100ps
`default_nettype none

// one read request lane, notifyWait -> lineReader
interface rdReqIf
   import pingPongPkg::*;
#(
   parameter int ADDR_LMT = 20
);

   logic                en;     // request pending
   logic [ADDR_LMT-1:0] addr;
   tagT                 tag;
   logic                sent;   // accepted this cycle

   // held steady until sent
   modport requester
   (
      output en,
      output addr,
      output tag,
      input  sent
   );

   modport arbiter
   (
      input  en,
      input  addr,
      input  tag,
      output sent
   );

endinterface

`default_nettype wire

//--- source/lineWriter.sv
`timescale 1ns/100ps
`default_nettype none

module lineWriter
   import pingPongPkg::*;
#(
   parameter int ADDR_LMT = 20,
   parameter int MDATA    = 14
)
(
   input  logic                Clk_400,
   input  logic                rstN,
   input  logic                go,
   input  logic [31:0]         numLines,
   input  logic                wrSent,
   output logic [ADDR_LMT-1:0] wrAddr,
   output tagT                 wrTag,
   output cacheLineT           wrData,
   output logic                wrFence,
   output logic                wrEn,
   output logic                wrDone
);

   wrStateT     wrState;
   logic [31:0] lineCnt;   // 1-based number of the line on the bus
   logic [16:0] addrLow;   // address merged into the payload

   assign addrLow = 17'(wrAddr);

   // flag line replaces the payload in the flag state
   assign wrData = (wrState == wrFlagS) ? FLAG_LINE : {PAYLOAD_FILL[511:17], addrLow};
   assign wrTag  = {1'b0, {(16-MDATA){1'b0}}, wrAddr[MDATA-2:0]};   // write tag

   assign wrEn    = (wrState == wrWriteS) || (wrState == wrFlagS);
   assign wrFence = (wrState == wrFenceS);
   assign wrDone  = (wrState == wrDoneS);

   // ********************
   // write FSM
   // ********************
   always_ff @(posedge Clk_400)
   begin
      if (!rstN)
      begin
         wrState <= wrWaitS;
         wrAddr  <= '0;
         lineCnt <= 32'd1;
      end
      else
      begin
         case (wrState)
            wrWaitS:
            begin
               wrAddr  <= '0;
               lineCnt <= 32'd1;
               if (go)
               begin
                  if (numLines != 32'd0)
                     wrState <= wrWriteS;
                  else
                     wrState <= wrFlagS;   // nothing to write, flag at address 0
               end
            end

            wrWriteS:
            begin
               if (wrSent)   // count only accepted lines
               begin
                  wrAddr  <= wrAddr + 1'b1;
                  lineCnt <= lineCnt + 32'd1;
                  if (lineCnt == numLines)
                     wrState <= wrFenceS;
               end
            end

            wrFenceS:
            begin
               if (wrSent)
                  wrState <= wrFlagS;   // wrAddr already at N
            end

            wrFlagS:
            begin
               if (wrSent)
                  wrState <= wrDoneS;
            end

            default:   // done, held until reset
            begin
               wrState <= wrState;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/notifyWait.sv
`timescale 1ns/100ps
`default_nettype none

module notifyWait
   import pingPongPkg::*;
#(
   parameter int ADDR_LMT = 20,
   parameter int MDATA    = 14
)
(
   input  logic        Clk_400,
   input  logic        rstN,
   input  logic [7:0]  testCfg,
   input  logic [31:0] numLines,
   input  logic        wrDone,
   input  logic        csrWrite,
   input  logic        flagSeen,
   input  logic        pollRspValid,
   rdReqIf.requester   pollReq,
   output logic        rdGo
);

   notifyModeT          mode;
   pollStateT           pollState;
   logic [ADDR_LMT-1:0] pollAddr;   // flag line sits right after the payload
   logic                pollHit;

   // 2 and 3 fall back to CSR
   assign mode = (testCfg[7:6] == 2'd0) ? notifyPoll : notifyCsr;

   assign pollAddr = numLines[ADDR_LMT-1:0];
   assign pollHit  = (pollState == pollRespS) && pollRspValid && flagSeen;

   // one-line poll read
   assign pollReq.en   = (pollState == pollReadS);
   assign pollReq.addr = pollAddr;
   assign pollReq.tag  = {1'b1, {(16-MDATA){1'b0}}, pollAddr[MDATA-2:0]};

   // ********************
   // poll FSM and go
   // ********************
   always_ff @(posedge Clk_400)
   begin
      if (!rstN)
      begin
         pollState <= pollWaitS;
         rdGo      <= 1'b0;
      end
      else
      begin
         // csr strobe only counts once the flag line is out
         if (mode == notifyPoll)
            rdGo <= pollHit;
         else
            rdGo <= csrWrite && wrDone;

         case (pollState)
            pollWaitS:
            begin
               if ((mode == notifyPoll) && wrDone)
                  pollState <= pollReadS;
            end

            pollReadS:
            begin
               if (pollReq.sent)
                  pollState <= pollRespS;
            end

            pollRespS:
            begin
               if (pollRspValid)
               begin
                  if (flagSeen)
                     pollState <= pollDoneS;
                  else
                     pollState <= pollReadS;   // host not ready, poll again
               end
            end

            default:
            begin
               pollState <= pollState;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/lineReader.sv
`timescale 1ns/100ps
`default_nettype none

module lineReader
   import pingPongPkg::*;
#(
   parameter int ADDR_LMT = 20,
   parameter int MDATA    = 14
)
(
   input  logic                Clk_400,
   input  logic                rstN,
   input  logic [31:0]         numLines,
   input  logic                rdGo,
   input  logic                rdSent,
   input  logic                allRsp,
   rdReqIf.arbiter             pollReq,
   output logic [ADDR_LMT-1:0] rdAddr,
   output tagT                 rdTag,
   output logic                rdEn,
   output logic                checkEn,
   output logic                rdDone
);

   rdStateT             rdState;
   logic [ADDR_LMT-1:0] payAddr;   // next payload line
   logic [31:0]         reqCnt;    // 1-based request number
   tagT                 payTag;

   assign payTag = {1'b1, {(16-MDATA){1'b0}}, payAddr[MDATA-2:0]};

   // ********************
   // read port mux
   // ********************
   always_comb
   begin
      if (rdState == rdWaitS)   // poll reads own the port while idle
      begin
         rdEn   = pollReq.en;
         rdAddr = pollReq.addr;
         rdTag  = pollReq.tag;
      end
      else
      begin
         rdEn   = (rdState == rdReadS);
         rdAddr = payAddr;
         rdTag  = payTag;
      end
   end

   assign pollReq.sent = (rdState == rdWaitS) && rdSent;

   assign checkEn = (rdState == rdReadS) || (rdState == rdDrainS);
   assign rdDone  = (rdState == rdDoneS);

   // ********************
   // payload read FSM
   // ********************
   always_ff @(posedge Clk_400)
   begin
      if (!rstN)
      begin
         rdState <= rdWaitS;
         payAddr <= '0;
         reqCnt  <= 32'd1;
      end
      else
      begin
         case (rdState)
            rdWaitS:
            begin
               payAddr <= '0;
               reqCnt  <= 32'd1;
               if (rdGo)
               begin
                  if (numLines != 32'd0)
                     rdState <= rdReadS;
                  else
                     rdState <= rdDoneS;   // empty run
               end
            end

            rdReadS:
            begin
               if (rdSent)
               begin
                  payAddr <= payAddr + 1'b1;
                  reqCnt  <= reqCnt + 32'd1;
                  if (reqCnt == numLines)   // last line issued
                     rdState <= rdDrainS;
               end
            end

            rdDrainS:
            begin
               if (allRsp)
                  rdState <= rdDoneS;
            end

            default:
            begin
               rdState <= rdState;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/rspChecker.sv
`timescale 1ns/100ps
`default_nettype none

module rspChecker
   import pingPongPkg::*;
#(
   parameter int ADDR_LMT = 20
)
(
   input  logic                Clk_400,
   input  logic                rstN,
   input  logic [31:0]         numLines,
   input  logic                checkEn,
   input  logic                rdRspValid,
   input  logic [ADDR_LMT-1:0] rdRspAddr,
   input  cacheLineT           rdData,
   output logic                flagSeen,
   output logic                pollRspValid,
   output logic                allRsp,
   output logic                errorValid,
   output logic [63:0]         errorInfo
);

   logic [31:0] rspCnt;     // payload responses so far
   logic        rspValidQ;
   logic [15:0] rspAddrQ;
   logic [15:0] rspDataQ;
   logic [31:0] rspCntQ;
   logic        mismatch;

   // anything before payload checking starts is a poll answer
   assign pollRspValid = rdRspValid && !checkEn;
   assign flagSeen     = rdRspValid && (rdData[63:32] == FLAG_WORD);
   assign allRsp       = (rspCnt == numLines);

   assign mismatch = rspValidQ && (rspDataQ != rspAddrQ);

   always_ff @(posedge Clk_400)
   begin
      if (!rstN)
      begin
         rspCnt    <= 32'd0;
         rspValidQ <= 1'b0;
      end
      else
      begin
         if (rdRspValid && checkEn)
            rspCnt <= rspCnt + 32'd1;
         rspValidQ <= rdRspValid && checkEn;
      end
   end

   // ********************
   // data check pipe
   // ********************
   always_ff @(posedge Clk_400)
   begin
      rspAddrQ <= 16'(rdRspAddr);
      rspDataQ <= rdData[15:0];   // low bits hold the address
      rspCntQ  <= rspCnt;
   end

   // sticky error, first failure kept
   always_ff @(posedge Clk_400)
   begin
      if (!rstN)
         errorValid <= 1'b0;
      else if (mismatch)
         errorValid <= 1'b1;
   end

   always_ff @(posedge Clk_400)
   begin
      if (mismatch && !errorValid)
         errorInfo <= {rspCntQ, rspAddrQ, rspDataQ};   // count, addr, data
   end

endmodule

`default_nettype wire

//--- source/pingPongTest.sv
`timescale 1ns/100ps
`default_nettype none

module pingPongTest
   import pingPongPkg::*;
#(
   parameter int ADDR_LMT = 20,
   parameter int MDATA    = 14
)
(
   input  logic                Clk_400,
   input  logic                rstN,
   input  logic                go,
   input  logic [31:0]         numLines,
   input  logic [7:0]          testCfg,
   input  logic                csrWrite,
   // write port
   output logic [ADDR_LMT-1:0] wrAddr,
   output tagT                 wrTag,
   output cacheLineT           wrData,
   output logic                wrFence,
   output logic                wrEn,
   input  logic                wrSent,
   // read port
   output logic [ADDR_LMT-1:0] rdAddr,
   output tagT                 rdTag,
   output logic                rdEn,
   input  logic                rdSent,
   // read responses
   input  logic                rdRspValid,
   input  logic [ADDR_LMT-1:0] rdRspAddr,
   input  cacheLineT           rdData,
   // status
   output logic                testCmp,
   output logic                errorValid,
   output logic [63:0]         errorInfo
);

   logic wrDone;
   logic rdGo;
   logic rdDone;
   logic flagSeen;
   logic pollRspValid;
   logic checkEn;
   logic allRsp;

   rdReqIf #(.ADDR_LMT(ADDR_LMT)) pollReq ();   // poll reads into the reader

   lineWriter #(.ADDR_LMT(ADDR_LMT), .MDATA(MDATA)) uWriter
   (
      .Clk_400, .rstN, .go, .numLines, .wrSent,
      .wrAddr, .wrTag, .wrData, .wrFence, .wrEn, .wrDone
   );

   notifyWait #(.ADDR_LMT(ADDR_LMT), .MDATA(MDATA)) uNotify
   (
      .Clk_400, .rstN, .testCfg, .numLines, .wrDone, .csrWrite,
      .flagSeen, .pollRspValid, .pollReq(pollReq.requester), .rdGo
   );

   lineReader #(.ADDR_LMT(ADDR_LMT), .MDATA(MDATA)) uReader
   (
      .Clk_400, .rstN, .numLines, .rdGo, .rdSent, .allRsp,
      .pollReq(pollReq.arbiter), .rdAddr, .rdTag, .rdEn, .checkEn, .rdDone
   );

   rspChecker #(.ADDR_LMT(ADDR_LMT)) uChecker
   (
      .Clk_400, .rstN, .numLines, .checkEn, .rdRspValid, .rdRspAddr, .rdData,
      .flagSeen, .pollRspValid, .allRsp, .errorValid, .errorInfo
   );

   // completion, held until reset
   always_ff @(posedge Clk_400)
   begin
      if (!rstN)
         testCmp <= 1'b0;
      else if (wrDone && rdDone)
         testCmp <= 1'b1;
   end

endmodule

`default_nettype wire

//--- sim/pingPongTest_assert.sv
`timescale 1ns/100ps
`default_nettype none

module pingPongTest_assert
   import pingPongPkg::*;
#(
   parameter int ADDR_LMT = 20
)
(
   input  logic                Clk_400,
   input  logic                rstN,
   input  logic                wrEn,
   input  logic                wrFence,
   input  logic                wrSent,
   input  logic [ADDR_LMT-1:0] wrAddr,
   input  tagT                 wrTag,
   input  cacheLineT           wrData,
   input  logic                rdEn,
   input  logic                rdSent,
   input  logic [ADDR_LMT-1:0] rdAddr,
   input  tagT                 rdTag,
   input  logic                testCmp
);

   int failCnt = 0;   // read back by the testbench

   // stalled requests hold still
   wrHold: assert property (@(posedge Clk_400) disable iff (!rstN)
      (wrEn && !wrSent) |=> (wrEn && $stable(wrAddr) && $stable(wrTag) && $stable(wrData)))
   else
   begin
      $error("write request changed while stalled");
      failCnt++;
   end

   fenceHold: assert property (@(posedge Clk_400) disable iff (!rstN)
      (wrFence && !wrSent) |=> wrFence)
   else
   begin
      $error("fence dropped while stalled");
      failCnt++;
   end

   rdHold: assert property (@(posedge Clk_400) disable iff (!rstN)
      (rdEn && !rdSent) |=> (rdEn && $stable(rdAddr) && $stable(rdTag)))
   else
   begin
      $error("read request changed while stalled");
      failCnt++;
   end

   wrExcl: assert property (@(posedge Clk_400) disable iff (!rstN) !(wrEn && wrFence))
   else
   begin
      $error("write and fence at once");
      failCnt++;
   end

   // completion only clears through reset
   cmpSticky: assert property (@(posedge Clk_400) $fell(testCmp) |-> !$past(rstN))
   else
   begin
      $error("testCmp fell without reset");
      failCnt++;
   end

endmodule

bind pingPongTest pingPongTest_assert #(.ADDR_LMT(ADDR_LMT)) uAssert (.*);

`default_nettype wire

//--- sim/pingPongTest_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pingPongTest_tb
   import pingPongPkg::*;
();

   localparam int ADDR_LMT = 20;
   localparam int MDATA    = 14;
   localparam int TIMEOUT  = 5000;   // cycles per wait

   logic                Clk_400;
   logic                rstN;
   logic                go;
   logic [31:0]         numLines;
   logic [7:0]          testCfg;
   logic                csrWrite;
   logic [ADDR_LMT-1:0] wrAddr;
   tagT                 wrTag;
   cacheLineT           wrData;
   logic                wrFence;
   logic                wrEn;
   logic                wrSent;
   logic [ADDR_LMT-1:0] rdAddr;
   tagT                 rdTag;
   logic                rdEn;
   logic                rdSent;
   logic                rdRspValid;
   logic [ADDR_LMT-1:0] rdRspAddr;
   cacheLineT           rdData;
   logic                testCmp;
   logic                errorValid;
   logic [63:0]         errorInfo;

   // current case
   int nLines;
   int mode;
   int corruptIdx;   // -1 for a clean run
   int expErr;

   // host model state
   bit        isPoll;
   bit        flagReturned;   // flag line handed back to a poll
   bit        csrPulsed;
   bit        csrArmed;
   int        csrDelay;
   int        nextRd;         // next expected payload read
   int        pollCnt;
   int        zeroPolls;      // polls answered "not ready"
   int        payRspCnt;
   int        rspAddr;
   int        caseCnt;
   int        fd;
   string     line;
   cacheLineT mem [int];      // host memory, by line address
   int        rspQ [$];       // accepted reads awaiting data
   int        wrKindQ [$];    // 0 line write, 1 fence
   int        wrAddrQ [$];
   cacheLineT wrDataQ [$];

   pingPongTest #(.ADDR_LMT(ADDR_LMT), .MDATA(MDATA)) UUT (.*);

   always #5 Clk_400 = ~Clk_400;

   // ********************
   // helpers
   // ********************
   task automatic stopRun(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check(input logic [511:0] got, input logic [511:0] exp, input string what);
      if (got !== exp)
         stopRun($sformatf("FAIL @ %0t: %s, got %0h expected %0h", $time, what, got, exp));
   endtask

   // read flag in bit 15, low address bits below
   function automatic tagT tagFor(input logic rd, input int addr);
      return {rd, 15'(addr % (1 << (MDATA - 1)))};
   endfunction

   function automatic cacheLineT payloadFor(input int k);
      cacheLineT ln;
      for (int w = 0; w < 16; w++)
         ln[w*32 +: 32] = 32'd1;   // 1 in every word
      ln[16:0] = k[16:0];           // line address in the low bits
      return ln;
   endfunction

   function automatic cacheLineT flagLine();
      cacheLineT ln;
      ln        = '0;
      ln[63:0]  = '1;
      return ln;
   endfunction

   // ********************
   // host side, drive on falling edge
   // ********************
   always @(negedge Clk_400)
   begin
      wrSent     = ($urandom % 4) != 0;   // stall about one in four
      rdSent     = ($urandom % 4) != 0;
      rdRspValid = 1'b0;
      csrWrite   = 1'b0;
      if (rspQ.size() > 0 && ($urandom % 3) != 0)   // random response latency
      begin
         rspAddr    = rspQ.pop_front();
         rdRspValid = 1'b1;
         rdRspAddr  = rspAddr[ADDR_LMT-1:0];
         if (isPoll && !flagReturned)
         begin
            pollCnt++;
            if (pollCnt > zeroPolls)
            begin
               rdData       = mem.exists(rspAddr) ? mem[rspAddr] : '0;
               flagReturned = 1'b1;
            end
            else
               rdData = '0;   // host not ready yet
         end
         else
         begin
            rdData = mem.exists(rspAddr) ? mem[rspAddr] : '0;
            if (rspAddr == corruptIdx)
               rdData[15:0] = ~rdData[15:0];   // damaged line
            payRspCnt++;
         end
      end
      if (csrArmed)
      begin
         if (csrDelay == 0)
         begin
            csrWrite = 1'b1;   // one-cycle strobe
            csrArmed = 1'b0;
         end
         else
            csrDelay--;
      end
   end

   // accepted requests, sampled on the rising edge
   always @(posedge Clk_400)
   begin
      if (rstN)
      begin
         if (wrEn && wrSent)
         begin
            check(wrTag, tagFor(1'b0, int'(wrAddr)), "write tag");
            mem[int'(wrAddr)] = wrData;
            wrKindQ.push_back(0);
            wrAddrQ.push_back(int'(wrAddr));
            wrDataQ.push_back(wrData);
            if (!isPoll && int'(wrAddr) == nLines)   // flag line out, answer by CSR
            begin
               csrArmed = 1'b1;
               csrDelay = $urandom % 6;
            end
         end
         if (wrFence && wrSent)
         begin
            wrKindQ.push_back(1);
            wrAddrQ.push_back(0);
            wrDataQ.push_back('0);
         end
         if (rdEn && rdSent)
         begin
            check(rdTag, tagFor(1'b1, int'(rdAddr)), "read tag");
            if (isPoll && !flagReturned)
               check(rdAddr, nLines, "poll read address");
            else
            begin
               if (!isPoll)
                  check(csrPulsed, 1'b1, "payload read before CSR strobe");
               check(rdAddr, nextRd, "payload read address");
               nextRd++;
            end
            rspQ.push_back(int'(rdAddr));
         end
         if (csrWrite)
            csrPulsed = 1'b1;
      end
   end

   // ********************
   // one case
   // ********************
   task automatic runCase();
      int          cycles;
      int          k;
      int          flagIdx;
      logic [15:0] badData;
      cycles = 0;
      @(negedge Clk_400);
      rstN     = 1'b0;
      go       = 1'b0;
      numLines = nLines;
      testCfg  = {mode[1:0], 6'b0};   // notify mode in bits 7:6
      @(posedge Clk_400);   // monitor idle in reset
      isPoll       = (mode == 0);
      flagReturned = 1'b0;
      csrPulsed    = 1'b0;
      csrArmed     = 1'b0;
      nextRd       = 0;
      pollCnt      = 0;
      payRspCnt    = 0;
      zeroPolls    = $urandom % 4;
      mem.delete();
      rspQ.delete();
      wrKindQ.delete();
      wrAddrQ.delete();
      wrDataQ.delete();
      repeat (3) @(negedge Clk_400);
      rstN = 1'b1;
      @(negedge Clk_400);
      go = 1'b1;
      @(negedge Clk_400);
      go = 1'b0;
      while (!testCmp && cycles < TIMEOUT)
      begin
         @(negedge Clk_400);
         cycles++;
      end
      if (!testCmp)
         stopRun($sformatf("timeout, test with %0d lines never completed", nLines));
      check(errorValid, expErr[0], "errorValid at completion");
      if (expErr != 0)
      begin
         badData = ~corruptIdx[15:0];
         check(errorInfo[15:0], badData, "errorInfo data");
      end
      check(nextRd, nLines, "payload reads issued");
      check(payRspCnt, nLines, "payload responses");
      check(rspQ.size(), 0, "reads left unanswered");
      // N lines, one fence, then the flag line
      flagIdx = (nLines == 0) ? 0 : nLines + 1;   // empty run writes the flag only
      check(wrKindQ.size(), flagIdx + 1, "accepted writes");
      for (k = 0; k < nLines; k++)
      begin
         check(wrKindQ[k], 0, "payload write kind");
         check(wrAddrQ[k], k, "payload write address");
         check(wrDataQ[k], payloadFor(k), "payload write data");
      end
      if (nLines != 0)
         check(wrKindQ[nLines], 1, "fence after payload");
      check(wrKindQ[flagIdx], 0, "flag write kind");
      check(wrAddrQ[flagIdx], nLines, "flag write address");
      check(wrDataQ[flagIdx], flagLine(), "flag write data");
      check(UUT.uAssert.failCnt, 0, "assertion failures");
   endtask

   initial
   begin
      void'($urandom(32'h2d70));   // seed once
      Clk_400    = 1'b0;
      rstN       = 1'b0;
      go         = 1'b0;
      numLines   = '0;
      testCfg    = '0;
      csrWrite   = 1'b0;
      wrSent     = 1'b0;
      rdSent     = 1'b0;
      rdRspValid = 1'b0;
      rdRspAddr  = '0;
      rdData     = '0;
      caseCnt    = 0;
      fd = $fopen("sim/pingPongTest_cases.txt", "r");
      if (fd == 0)
         stopRun("cannot open the case file sim/pingPongTest_cases.txt");
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#")   // skip comments and blanks
         begin
            if ($sscanf(line, "%d %d %d %d", nLines, mode, corruptIdx, expErr) == 4)
            begin
               runCase();
               caseCnt++;
            end
         end
      end
      $fclose(fd);
      if (caseCnt == 0)
         stopRun("no test cases were read from the case file");
      else
      begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- sim/pingPongTest_cases.txt
# numLines mode corruptIdx expErr
# mode 0 poll, 1 CSR (2 and 3 act as CSR), corruptIdx -1 for a clean run
4 0 -1 0
4 1 -1 0
0 0 -1 0
0 1 -1 0
1 0 0 1
7 1 3 1
16 0 -1 0
9 2 8 1
12 3 -1 0
5 0 2 1
20 1 -1 0
3 0 -1 0

//--- pingPongTest.f
source/pingPongPkg.sv
source/rdReqIf.sv
source/lineWriter.sv
source/notifyWait.sv
source/lineReader.sv
source/rspChecker.sv
source/pingPongTest.sv
sim/pingPongTest_assert.sv
sim/pingPongTest_tb.sv

//--- Bender.yml
package:
  name: pingPongTest

sources:
  - source/pingPongPkg.sv
  - source/rdReqIf.sv
  - source/lineWriter.sv
  - source/notifyWait.sv
  - source/lineReader.sv
  - source/rspChecker.sv
  - source/pingPongTest.sv
  - target: simulation
    files:
      - sim/pingPongTest_assert.sv
      - sim/pingPongTest_tb.sv
